/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module copper_tb -Mdir obj_dir -f copper_top.f
	@out="$$(./obj_dir/Vcopper_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

/* copper_top.f */
verilog/copp_pkg.sv
verilog/copp_exec_if.sv
verilog/copp_sequencer.sv
verilog/copp_exec.sv
verilog/copper_top.sv
sim/copper_tb.sv

/* sim/copper_tb.sv */
// Copper testbench running a short program through WAIT, SKIP, JMP, RSVD and MOVE
`timescale 1ns/1ps

module copper_tb;
    import copp_pkg::*;

    // Short frames keep the run brief
    localparam int H_TOTAL = 64;
    localparam int V_TOTAL = 16;
    // Three frames of program plus one spare frame and margin
    localparam int TIMEOUT_CYCLES = 4 * H_TOTAL * V_TOTAL + 200;
    localparam logic [HPOS_W-1:0] H_LAST    = 11'd63;
    localparam logic [VPOS_W-1:0] V_LAST    = 11'd15;
    localparam logic [HPOS_W-1:0] H_RESTART = 11'd60;
    localparam logic [COPP_W-1:0] INIT_PC   = 11'h010;

    logic              clk;
    logic              copp_reset;
    logic              reg_wr_i;
    logic [WORD_W-1:0] reg_data_i;
    logic [HPOS_W-1:0] h_count_i;
    logic [VPOS_W-1:0] v_count_i;
    logic              mem_rd_en_o;
    logic [COPP_W-1:0] mem_rd_addr_o;
    logic [31:0]       mem_rd_data_i;
    logic              xr_wr_en_o;
    logic [WORD_W-1:0] xr_wr_addr_o;
    logic [WORD_W-1:0] xr_wr_data_o;
    logic              xr_wr_ack_i;

    logic [31:0]       copper_mem [2048];
    logic [WORD_W-1:0] exp_addr [3];
    logic [WORD_W-1:0] exp_data [3];
    logic [1:0]        write_slot;
    logic [COPP_W-1:0] last_fetch;
    logic              enable_sent;
    logic              restart_pending;
    logic              rd_en_s;
    logic [COPP_W-1:0] rd_addr_s;
    integer            seed = 32'hdac2_3711;
    int                ack_wait;
    int                cycle_count;
    int                error_count [8];
    int                disabled_cycles;
    int                writes_done;
    int                first_writes;
    int                jump_fetches;
    int                restart_fetches;

    // Wrong value with expected and actual
    task automatic mismatch_error(input int behavior, input string name,
                                  input logic [31:0] expected, input logic [31:0] actual);
        $display("[ERROR] %0t %s expected %0h got %0h", $time, name, expected, actual);
        error_count[behavior[2:0]] = error_count[behavior[2:0]] + 1;
    endtask

    task automatic plain_error(input int behavior, input string text);
        $display("Failure at %0t: %s", $time, text);
        error_count[behavior[2:0]] = error_count[behavior[2:0]] + 1;
    endtask

    // Summary line for one behavior with its check count
    task automatic close_behavior(input int behavior, input int checks, input int needed,
                                  input string name);
        if (checks < needed) begin
            plain_error(behavior, $sformatf("%s was reached %0d times, %0d expected",
                                            name, checks, needed));
        end
        $display("%s: %0d checks, %0d errors", name, checks, error_count[behavior[2:0]]);
    endtask

    // WAIT and SKIP word from the position layout
    function automatic logic [31:0] pos_word(input logic [2:0] op, input logic [10:0] v,
                                             input logic [10:0] h, input logic ign_h,
                                             input logic ign_v);
        return {op, 2'b00, v, 1'b0, h, 2'b00, ign_h, ign_v};
    endfunction

    function automatic logic [31:0] move_word(input logic [2:0] op, input logic [12:0] target,
                                              input logic [15:0] data);
        return {op, target, data};
    endfunction

    // JMP target sits in bits 27:17
    function automatic logic [31:0] jump_word(input logic [10:0] pc);
        return {OP_JUMP, 1'b0, pc, 17'd0};
    endfunction

    copper_top #(
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL)
    ) u_dut (
        .clk           (clk),
        .copp_reset    (copp_reset),
        .reg_wr_i      (reg_wr_i),
        .reg_data_i    (reg_data_i),
        .h_count_i     (h_count_i),
        .v_count_i     (v_count_i),
        .mem_rd_en_o   (mem_rd_en_o),
        .mem_rd_addr_o (mem_rd_addr_o),
        .mem_rd_data_i (mem_rd_data_i),
        .xr_wr_en_o    (xr_wr_en_o),
        .xr_wr_addr_o  (xr_wr_addr_o),
        .xr_wr_data_o  (xr_wr_data_o),
        .xr_wr_ack_i   (xr_wr_ack_i)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
    end

    // Free-running pixel counters
    always @(posedge clk) begin
        #1;
        if (h_count_i == H_LAST) begin
            h_count_i = '0;
            v_count_i = (v_count_i == V_LAST) ? '0 : v_count_i + 1'b1;
        end else begin
            h_count_i = h_count_i + 1'b1;
        end
    end

    // Copper memory returns the word one cycle after the strobe and holds it
    always @(posedge clk) begin
        rd_en_s   = mem_rd_en_o;
        rd_addr_s = mem_rd_addr_o;
        #1;
        if (rd_en_s) begin
            mem_rd_data_i = copper_mem[rd_addr_s];
        end
    end

    // XR ack as a single cycle pulse 0 to 3 cycles into the write
    always @(posedge clk) begin
        #1;
        if (copp_reset || xr_wr_ack_i) begin
            xr_wr_ack_i = 1'b0;
            ack_wait    = -1;
        end else if (xr_wr_en_o) begin
            if (ack_wait < 0) begin
                ack_wait = $random(seed) & 3;
            end
            if (ack_wait == 0) begin
                xr_wr_ack_i = 1'b1;
            end else begin
                ack_wait = ack_wait - 1;
            end
        end
    end

    // Write order, fetch history and restart tracking
    always @(posedge clk) begin
        if (copp_reset) begin
            write_slot      <= '0;
            last_fetch      <= '0;
            restart_pending <= 1'b0;
            disabled_cycles <= 0;
            writes_done     <= 0;
            first_writes    <= 0;
            jump_fetches    <= 0;
            restart_fetches <= 0;
        end else begin
            if (!enable_sent) begin
                disabled_cycles <= disabled_cycles + 1;
            end
            if (xr_wr_en_o && xr_wr_ack_i) begin
                write_slot  <= (write_slot == 2'd2) ? 2'd0 : write_slot + 2'd1;
                writes_done <= writes_done + 1;
                if (write_slot == 2'd0) begin
                    first_writes <= first_writes + 1;
                end
            end
            if (mem_rd_en_o) begin
                last_fetch <= mem_rd_addr_o;
                if (last_fetch == 11'h014) begin
                    jump_fetches <= jump_fetches + 1;
                end
            end
            // Restart cycle four pixels before the end of the last line
            if (h_count_i == H_RESTART && v_count_i == V_LAST) begin
                restart_pending <= 1'b1;
            end else if (mem_rd_en_o && restart_pending) begin
                restart_pending <= 1'b0;
                restart_fetches <= restart_fetches + 1;
            end
        end
    end

    // Nothing moves before the enable bit is written
    assert property (@(posedge clk) disable iff (copp_reset) !enable_sent |-> !mem_rd_en_o)
        else mismatch_error(1, "mem_rd_en_o", 32'd0, 32'($sampled(mem_rd_en_o)));
    assert property (@(posedge clk) disable iff (copp_reset) !enable_sent |-> !xr_wr_en_o)
        else mismatch_error(1, "xr_wr_en_o", 32'd0, 32'($sampled(xr_wr_en_o)));

    // Writes in program order with region bits and encoded word
    assert property (@(posedge clk) disable iff (copp_reset)
        $rose(xr_wr_en_o) |-> xr_wr_addr_o == exp_addr[write_slot])
        else mismatch_error(2, "xr_wr_addr_o", 32'(exp_addr[$sampled(write_slot)]),
                            32'($sampled(xr_wr_addr_o)));
    assert property (@(posedge clk) disable iff (copp_reset)
        $rose(xr_wr_en_o) |-> xr_wr_data_o == exp_data[write_slot])
        else mismatch_error(2, "xr_wr_data_o", 32'(exp_data[$sampled(write_slot)]),
                            32'($sampled(xr_wr_data_o)));
    assert property (@(posedge clk) disable iff (copp_reset)
        (xr_wr_en_o && !xr_wr_ack_i) |=>
        (xr_wr_en_o && $stable(xr_wr_addr_o) && $stable(xr_wr_data_o)))
        else plain_error(2, "a write was dropped or changed before its ack");

    // First write of each frame waits for line 4
    assert property (@(posedge clk) disable iff (copp_reset)
        ($rose(xr_wr_en_o) && write_slot == 2'd0) |-> v_count_i >= 11'd4)
        else plain_error(3, $sformatf("first write began on line %0d, before line 4",
                                      $sampled(v_count_i)));

    // Skipped MOVEP never reaches the color region
    assert property (@(posedge clk) disable iff (copp_reset)
        xr_wr_en_o |-> xr_wr_addr_o[15:13] != XR_COLOR_BASE[15:13])
        else plain_error(4, "a write reached the color region");
    assert property (@(posedge clk) disable iff (copp_reset)
        (mem_rd_en_o && last_fetch == 11'h014) |-> mem_rd_addr_o == 11'h020)
        else mismatch_error(4, "mem_rd_addr_o", 32'h020, 32'($sampled(mem_rd_addr_o)));
    // A write always belongs to the MOVE fetched last
    assert property (@(posedge clk) disable iff (copp_reset)
        $rose(xr_wr_en_o) |-> last_fetch != 11'h020)
        else plain_error(4, "the reserved opcode started a write");

    // Each frame restarts at the initial PC
    assert property (@(posedge clk) disable iff (copp_reset)
        (mem_rd_en_o && restart_pending) |-> mem_rd_addr_o == INIT_PC)
        else mismatch_error(5, "mem_rd_addr_o", 32'(INIT_PC), 32'($sampled(mem_rd_addr_o)));

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Errors found");
        $finish;
    end

    initial begin
        int addr;
        int total;
        clk           = 1'b0;
        copp_reset    = 1'b1;
        reg_wr_i      = 1'b0;
        reg_data_i    = '0;
        h_count_i     = '0;
        v_count_i     = '0;
        mem_rd_data_i = '0;
        xr_wr_ack_i   = 1'b0;
        enable_sent   = 1'b0;
        ack_wait      = -1;
        // Unused words decode as RSVD and carry their own address
        for (addr = 0; addr < 2048; addr++) begin
            copper_mem[addr[10:0]] = {OP_RSVD, 18'd0, addr[10:0]};
        end
        // Horizontal target lies past the line end so only the ignore flag lets it pass
        copper_mem[11'h010] = pos_word(OP_WAIT, 11'd4, 11'd100, 1'b1, 1'b0);
        copper_mem[11'h011] = move_word(OP_MOVER, 13'h1A5, 16'h1234);
        copper_mem[11'h012] = pos_word(OP_SKIP, 11'd2, 11'd0, 1'b0, 1'b0);
        copper_mem[11'h013] = move_word(OP_MOVEP, 13'h155, 16'hBEEF);
        copper_mem[11'h014] = jump_word(11'h020);
        copper_mem[11'h020] = 32'hE000_0000;
        copper_mem[11'h021] = move_word(OP_MOVEF, 13'h1ABC, 16'h5A5A);
        copper_mem[11'h022] = move_word(OP_MOVEC, 13'h13C7, 16'h0F0F);
        copper_mem[11'h023] = pos_word(OP_WAIT, 11'd0, 11'd0, 1'b1, 1'b1);
        // MOVER keeps 8 target bits, MOVEF 13, MOVEC 11
        exp_addr[0] = {XR_REGS_BASE[15:13], 5'd0, 8'hA5};
        exp_data[0] = 16'h1234;
        exp_addr[1] = {XR_TILE_BASE[15:13], 13'h1ABC};
        exp_data[1] = 16'h5A5A;
        exp_addr[2] = {XR_COPPER_BASE[15:13], 2'd0, 11'h3C7};
        exp_data[2] = 16'h0F0F;
        repeat (10) @(posedge clk);
        #1 copp_reset = 1'b0;
        // Idle stretch with the copper still disabled
        repeat (20) @(posedge clk);
        #1;
        reg_wr_i    = 1'b1;
        reg_data_i  = {1'b1, 4'd0, INIT_PC};
        enable_sent = 1'b1;
        @(posedge clk);
        #1 reg_wr_i = 1'b0;
        // Third restart fetch closes the third frame
        wait (restart_fetches >= 3);
        repeat (4) @(posedge clk);
        close_behavior(1, disabled_cycles, 1, "reset and disable");
        close_behavior(2, writes_done, 9, "MOVE writes");
        close_behavior(3, first_writes, 3, "WAIT");
        close_behavior(4, jump_fetches, 3, "SKIP, JMP and RSVD");
        close_behavior(5, restart_fetches, 3, "frame restart");
        total = error_count[1] + error_count[2] + error_count[3] + error_count[4]
              + error_count[5];
        $display("5 behaviors run, %0d errors in total", total);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* verilog/copp_exec.sv */
// Copper executer doing position compare, condition evaluation and MOVE writes on the XR bus
`timescale 1ns/1ps

module copp_exec (
    input  logic                        clk,
    input  logic                        copp_reset,
    output logic                        xr_wr_en_o,
    output logic [copp_pkg::WORD_W-1:0] xr_wr_addr_o,
    output logic [copp_pkg::WORD_W-1:0] xr_wr_data_o,
    input  logic                        xr_wr_ack_i,
    copp_exec_if.exe                    exec_bus
);
    import copp_pkg::*;

    logic              v_reached;
    logic              h_reached;
    logic              in_exec;
    copp_opcode_e      opcode;
    logic              v_met;
    logic              h_met;
    logic              pos_met;
    logic              both_ignored;
    logic              is_move;
    logic              move_fire;
    logic              done;
    logic              jump;
    logic              skip;
    logic [WORD_W-1:0] move_addr;

    assign in_exec = (exec_bus.state == ST_EXEC);
    assign opcode  = exec_bus.insn.move.opcode;

    // Position compares registered in PRECOMP
    always_ff @(posedge clk) begin
        if (exec_bus.state == ST_PRECOMP) begin
            v_reached <= (exec_bus.v_count >= exec_bus.insn.pos.v_pos);
            h_reached <= (exec_bus.h_count >= exec_bus.insn.pos.h_pos);
        end
    end

    // Ignored axis counts as met
    assign v_met        = exec_bus.insn.pos.ignore_v | v_reached;
    assign h_met        = exec_bus.insn.pos.ignore_h | h_reached;
    assign pos_met      = v_met & h_met;
    assign both_ignored = exec_bus.insn.pos.ignore_v & exec_bus.insn.pos.ignore_h;

    // Region top bits plus the low target bits
    always_comb begin
        case (opcode)
            OP_MOVER: move_addr = {XR_REGS_BASE[15:13], 13'(exec_bus.insn.move.target[7:0])};
            OP_MOVEF: move_addr = {XR_TILE_BASE[15:13], exec_bus.insn.move.target};
            OP_MOVEP: move_addr = {XR_COLOR_BASE[15:13], 13'(exec_bus.insn.move.target[8:0])};
            default:  move_addr = {XR_COPPER_BASE[15:13],
                                   13'(exec_bus.insn.move.target[COPP_W-1:0])};
        endcase
    end

    // Condition evaluation
    // All results stay low outside EXEC
    always_comb begin
        done    = 1'b0;
        jump    = 1'b0;
        skip    = 1'b0;
        is_move = 1'b0;
        if (in_exec) begin
            case (opcode)
                // Both axes ignored waits for the frame restart
                OP_WAIT:  done = pos_met & ~both_ignored;
                OP_SKIP: begin
                    done = 1'b1;
                    skip = pos_met;
                end
                OP_JUMP: begin
                    done = 1'b1;
                    jump = 1'b1;
                end
                OP_MOVER, OP_MOVEF, OP_MOVEP, OP_MOVEC: begin
                    is_move = 1'b1;
                    // Stall while the previous write is outstanding
                    done    = ~xr_wr_en_o;
                end
                OP_RSVD:  done = 1'b1;
            endcase
        end
    end

    assign move_fire = is_move & ~xr_wr_en_o;

    assign exec_bus.exec_done = done;
    assign exec_bus.jump_take = jump;
    assign exec_bus.skip_take = skip;
    assign exec_bus.jump_pc   = jump ? exec_bus.insn.move.target[COPP_W:1] : '0;

    // Write enable held until the ack edge
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            xr_wr_en_o <= 1'b0;
        end else if (move_fire) begin
            xr_wr_en_o <= 1'b1;
        end else if (xr_wr_ack_i) begin
            xr_wr_en_o <= 1'b0;
        end
    end

    // Address and data captured with the enable
    always_ff @(posedge clk) begin
        if (move_fire) begin
            xr_wr_addr_o <= move_addr;
            xr_wr_data_o <= exec_bus.insn.move.data;
        end
    end

    // Pending write keeps enable, address and data until acked
    assert property (@(posedge clk) disable iff (copp_reset)
        (xr_wr_en_o && !xr_wr_ack_i) |=>
        (xr_wr_en_o && $stable(xr_wr_addr_o) && $stable(xr_wr_data_o)));

endmodule

/* verilog/copp_exec_if.sv */
// Execution bus between the copper sequencer and the copper executer
`timescale 1ns/1ps

interface copp_exec_if;
    import copp_pkg::*;

    // Latched instruction and current FSM state
    copp_insn_u        insn;
    copp_state_e       state;

    // Pixel position as seen by the sequencer
    logic [HPOS_W-1:0] h_count;
    logic [VPOS_W-1:0] v_count;

    // Results of the EXEC cycle
    logic              exec_done;
    logic              jump_take;
    logic [COPP_W-1:0] jump_pc;
    logic              skip_take;

    // Sequencer side
    modport seq (
        output insn, state, h_count, v_count,
        input  exec_done, jump_take, jump_pc, skip_take
    );

    // Executer side
    modport exe (
        input  insn, state, h_count, v_count,
        output exec_done, jump_take, jump_pc, skip_take
    );

endinterface

/* verilog/copp_pkg.sv */
// Copper shared definitions for widths, opcodes, FSM states, instruction views and XR regions
package copp_pkg;

    // Program counter and copper memory address width
    localparam int COPP_W = 11;

    // Pixel counter widths
    localparam int HPOS_W = 11;
    localparam int VPOS_W = 11;

    // XR bus address and data width
    localparam int WORD_W = 16;

    // Instruction opcodes in bits 31:29
    typedef enum logic [2:0] {
        OP_WAIT  = 3'b000,
        OP_SKIP  = 3'b001,
        OP_JUMP  = 3'b010,
        OP_MOVER = 3'b011,
        OP_MOVEF = 3'b100,
        OP_MOVEP = 3'b101,
        OP_MOVEC = 3'b110,
        OP_RSVD  = 3'b111
    } copp_opcode_e;

    // Fetch and execution states
    typedef enum logic [2:0] {
        ST_INIT       = 3'd0,
        ST_FETCH_WAIT = 3'd1,
        ST_LATCH      = 3'd2,
        ST_PRECOMP    = 3'd3,
        ST_EXEC       = 3'd4
    } copp_state_e;

    // WAIT and SKIP view of an instruction word
    typedef struct packed {
        copp_opcode_e      opcode;
        logic [1:0]        rsvd_hi;
        logic [VPOS_W-1:0] v_pos;
        logic              rsvd_mid;
        logic [HPOS_W-1:0] h_pos;
        logic [1:0]        rsvd_lo;
        logic              ignore_h;
        logic              ignore_v;
    } copp_pos_t;

    // MOVE and JMP view of an instruction word
    // JMP target sits in target[11:1]
    typedef struct packed {
        copp_opcode_e      opcode;
        logic [12:0]       target;
        logic [WORD_W-1:0] data;
    } copp_move_t;

    // One 32-bit word with both decodings
    typedef union packed {
        copp_pos_t  pos;
        copp_move_t move;
    } copp_insn_u;

    // XR region bases and only bits 15:13 select the region
    localparam logic [WORD_W-1:0] XR_REGS_BASE   = 16'h0000;
    localparam logic [WORD_W-1:0] XR_TILE_BASE   = 16'h4000;
    localparam logic [WORD_W-1:0] XR_COLOR_BASE  = 16'h8000;
    localparam logic [WORD_W-1:0] XR_COPPER_BASE = 16'hC000;

endpackage

/* verilog/copp_sequencer.sv */
// Copper sequencer holding the control register, frame restart, program counter and fetch FSM
`timescale 1ns/1ps

module copp_sequencer #(
    parameter int H_TOTAL = 800,
    parameter int V_TOTAL = 525
) (
    input  logic                        clk,
    input  logic                        copp_reset,
    input  logic                        reg_wr_i,
    input  logic [copp_pkg::WORD_W-1:0] reg_data_i,
    input  logic [copp_pkg::HPOS_W-1:0] h_count_i,
    input  logic [copp_pkg::VPOS_W-1:0] v_count_i,
    output logic                        mem_rd_en_o,
    output logic [copp_pkg::COPP_W-1:0] mem_rd_addr_o,
    input  logic [31:0]                 mem_rd_data_i,
    copp_exec_if.seq                    exec_bus
);
    import copp_pkg::*;

    // Restart point a few pixels before the end of the last line
    localparam logic [HPOS_W-1:0] H_RESTART = HPOS_W'(H_TOTAL - 4);
    localparam logic [VPOS_W-1:0] V_RESTART = VPOS_W'(V_TOTAL - 1);

    logic              copper_en;
    logic [COPP_W-1:0] init_pc;
    logic [COPP_W-1:0] pc;
    copp_state_e       state;
    copp_insn_u        insn;
    logic              frame_restart;

    assign frame_restart = (h_count_i == H_RESTART) && (v_count_i == V_RESTART);

    // Fetch address follows the PC
    // PC only advances on the edge that ends the strobe cycle
    assign mem_rd_addr_o = pc;

    // Drive the execution bus
    assign exec_bus.insn    = insn;
    assign exec_bus.state   = state;
    assign exec_bus.h_count = h_count_i;
    assign exec_bus.v_count = v_count_i;

    // Control register
    // Enable in bit 15 and initial PC in the low bits
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            copper_en <= 1'b0;
            init_pc   <= '0;
        end else if (reg_wr_i) begin
            copper_en <= reg_data_i[15];
            init_pc   <= reg_data_i[COPP_W-1:0];
        end
    end

    // Memory word is valid in LATCH
    always_ff @(posedge clk) begin
        if (state == ST_LATCH) begin
            insn <= mem_rd_data_i;
        end
    end

    // Fetch and execution FSM
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            state       <= ST_INIT;
            pc          <= '0;
            mem_rd_en_o <= 1'b0;
        end else begin
            // Strobe is single cycle
            mem_rd_en_o <= 1'b0;
            if (frame_restart) begin
                // Restart the program for the next frame
                state <= ST_INIT;
                pc    <= init_pc;
            end else begin
                case (state)
                    ST_INIT: begin
                        // Start from the initial PC once enabled
                        pc <= init_pc;
                        if (copper_en) begin
                            state       <= ST_FETCH_WAIT;
                            mem_rd_en_o <= 1'b1;
                        end
                    end
                    ST_FETCH_WAIT: begin
                        if (copper_en) begin
                            state <= ST_LATCH;
                            pc    <= pc + 1'b1;
                        end else begin
                            // Disabled so park in INIT
                            state <= ST_INIT;
                        end
                    end
                    ST_LATCH: begin
                        state <= ST_PRECOMP;
                    end
                    ST_PRECOMP: begin
                        state <= ST_EXEC;
                    end
                    ST_EXEC: begin
                        if (exec_bus.exec_done) begin
                            if (exec_bus.jump_take) begin
                                pc <= exec_bus.jump_pc;
                            end else if (exec_bus.skip_take) begin
                                pc <= pc + 1'b1;
                            end
                            // Issue the next fetch
                            state       <= ST_FETCH_WAIT;
                            mem_rd_en_o <= 1'b1;
                        end else if (insn.move.opcode == OP_WAIT) begin
                            // Unmet WAIT goes back to compare again
                            state <= ST_PRECOMP;
                        end
                        // Stalled MOVE holds in EXEC
                    end
                    default: begin
                        state <= ST_INIT;
                    end
                endcase
            end
        end
    end

    // Disabled copper in INIT never starts a fetch
    assert property (@(posedge clk) disable iff (copp_reset)
        (state == ST_INIT && !copper_en) |=> !mem_rd_en_o);

    // FSM stays within its encoding
    assert property (@(posedge clk) disable iff (copp_reset)
        state inside {ST_INIT, ST_FETCH_WAIT, ST_LATCH, ST_PRECOMP, ST_EXEC});

endmodule

/* verilog/copper_top.sv */
// Display copper top level joining the sequencer and the executer over the execution bus
`timescale 1ns/1ps

module copper_top #(
    // Video totals for the active timing
    parameter int H_TOTAL = 800,
    parameter int V_TOTAL = 525
) (
    input  logic                        clk,
    input  logic                        copp_reset,
    input  logic                        reg_wr_i,
    input  logic [copp_pkg::WORD_W-1:0] reg_data_i,
    input  logic [copp_pkg::HPOS_W-1:0] h_count_i,
    input  logic [copp_pkg::VPOS_W-1:0] v_count_i,
    output logic                        mem_rd_en_o,
    output logic [copp_pkg::COPP_W-1:0] mem_rd_addr_o,
    input  logic [31:0]                 mem_rd_data_i,
    output logic                        xr_wr_en_o,
    output logic [copp_pkg::WORD_W-1:0] xr_wr_addr_o,
    output logic [copp_pkg::WORD_W-1:0] xr_wr_data_o,
    input  logic                        xr_wr_ack_i
);

    // Instruction, state and results between the two halves
    copp_exec_if exec_bus ();

    // Fetch side with control register and frame restart
    copp_sequencer #(
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL)
    ) u_seq (
        .clk           (clk),
        .copp_reset    (copp_reset),
        .reg_wr_i      (reg_wr_i),
        .reg_data_i    (reg_data_i),
        .h_count_i     (h_count_i),
        .v_count_i     (v_count_i),
        .mem_rd_en_o   (mem_rd_en_o),
        .mem_rd_addr_o (mem_rd_addr_o),
        .mem_rd_data_i (mem_rd_data_i),
        .exec_bus      (exec_bus)
    );

    // Condition evaluation and XR write port
    copp_exec u_exe (
        .clk          (clk),
        .copp_reset   (copp_reset),
        .xr_wr_en_o   (xr_wr_en_o),
        .xr_wr_addr_o (xr_wr_addr_o),
        .xr_wr_data_o (xr_wr_data_o),
        .xr_wr_ack_i  (xr_wr_ack_i),
        .exec_bus     (exec_bus)
    );

endmodule
